// File: include/heptagon_config.svh
`ifndef HEPTAGON_CONFIG_SVH
`define HEPTAGON_CONFIG_SVH

// Point coordinates, unsigned
`define COORD_W    10

`define NUM_HEPT   5
`define NUM_VERT   7
`define NUM_POINTS 35

// Output fields
`define AREA_W     19
`define INDEX_W    3

`endif

// File: src/heptagon_pkg.sv
`default_nettype none

`include "heptagon_config.svh"

package heptagon_pkg;

    typedef struct packed {
        logic [`COORD_W-1:0] x;
        logic [`COORD_W-1:0] y;
    } point_t;

    typedef logic [5:0] addr_t;                 // Point address in the store
    typedef logic [2:0] hept_t;
    typedef logic signed [21:0] twice_area_t;

    typedef struct packed {
        logic [`INDEX_W-1:0] index;             // 1-based heptagon number
        logic [`AREA_W-1:0]  area;
    } rank_t;

    typedef enum logic [2:0] {IDLE, LOAD_REF, COMPARE, NEXT_REF, DONE} sort_state_t;
    typedef enum logic [1:0] {COLLECT, SORT, EMIT, FINISH} rank_state_t;

    // Cross product of (a - o) and (b - o), positive when b lies counterclockwise of a
    function automatic twice_area_t cross_at(point_t o, point_t a, point_t b);
        logic signed [`COORD_W:0] ax, ay, bx, by;
        ax = $signed({1'b0, a.x}) - $signed({1'b0, o.x});
        ay = $signed({1'b0, a.y}) - $signed({1'b0, o.y});
        bx = $signed({1'b0, b.x}) - $signed({1'b0, o.x});
        by = $signed({1'b0, b.y}) - $signed({1'b0, o.y});
        return ax * by - bx * ay;
    endfunction

endpackage

`default_nettype wire

// File: src/vertex_store.sv
`timescale 1ns/1ps
`default_nettype none

`include "heptagon_config.svh"

module vertex_store import heptagon_pkg::*; (
    input  wire                 clk,
    input  wire                 reset,
    input  wire  [`COORD_W-1:0] x,
    input  wire  [`COORD_W-1:0] y,
    output logic                load_done,
    input  wire  addr_t         sort_addr_a,
    input  wire  addr_t         sort_addr_b,
    input  wire                 swap,
    output point_t              pt_a,
    output point_t              pt_b,
    input  wire  addr_t         area_addr,
    output point_t              area_pt
);

    point_t mem [`NUM_POINTS];
    logic   loading;
    addr_t  count;

    // Load window opens on the first edge after reset
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            loading   <= 1'b1;
            count     <= '0;
            load_done <= 1'b0;
        end else begin
            load_done <= 1'b0;
            if (loading) begin
                if (count == addr_t'(`NUM_POINTS - 1)) begin
                    loading   <= 1'b0;
                    load_done <= 1'b1;
                end else begin
                    count <= count + 6'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (loading) begin
            mem[count] <= {x, y};
        end else if (swap) begin
            mem[sort_addr_a] <= pt_b;   // In-place exchange
            mem[sort_addr_b] <= pt_a;
        end
    end

    assign pt_a    = mem[sort_addr_a];
    assign pt_b    = mem[sort_addr_b];
    assign area_pt = mem[area_addr];

    a_no_swap_in_load: assert property (
        @(posedge clk) disable iff (reset) loading |-> !swap
    );

endmodule

`default_nettype wire

// File: src/angular_sorter.sv
`timescale 1ns/1ps
`default_nettype none

`include "heptagon_config.svh"

module angular_sorter import heptagon_pkg::*; (
    input  wire         clk,
    input  wire         reset,
    input  wire         load_done,
    output addr_t       sort_addr_a,
    output addr_t       sort_addr_b,
    input  wire point_t pt_a,
    input  wire point_t pt_b,
    output logic        swap,
    output logic        sort_done
);

    sort_state_t state;
    hept_t       hept;
    logic [2:0]  ref_slot;
    logic [2:0]  cmp_slot;
    point_t      anchor;
    addr_t       base;
    twice_area_t cp;

    assign base        = addr_t'(hept) * addr_t'(`NUM_VERT);
    assign sort_addr_a = base + addr_t'(ref_slot);
    assign sort_addr_b = (state == LOAD_REF) ? base : base + addr_t'(cmp_slot);

    // Port a always shows the current point in the reference slot, even right after a swap
    assign cp        = cross_at(anchor, pt_a, pt_b);
    assign swap      = (state == COMPARE) && (cp < 0);
    assign sort_done = (state == DONE);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= IDLE;
            hept     <= '0;
            ref_slot <= 3'd1;
            cmp_slot <= 3'd2;
        end else begin
            case (state)
                IDLE: begin
                    if (load_done) begin
                        state    <= LOAD_REF;
                        hept     <= '0;
                        ref_slot <= 3'd1;
                    end
                end
                LOAD_REF: begin
                    cmp_slot <= ref_slot + 3'd1;
                    state    <= COMPARE;
                end
                COMPARE: begin
                    cmp_slot <= cmp_slot + 3'd1;
                    if (cmp_slot == 3'(`NUM_VERT - 1)) begin
                        state <= NEXT_REF;
                    end
                end
                NEXT_REF: begin
                    if (ref_slot == 3'(`NUM_VERT - 2)) begin
                        if (hept == hept_t'(`NUM_HEPT - 1)) begin
                            state <= DONE;
                        end else begin
                            hept     <= hept + 3'd1;
                            ref_slot <= 3'd1;
                            state    <= LOAD_REF;
                        end
                    end else begin
                        ref_slot <= ref_slot + 3'd1;
                        state    <= LOAD_REF;
                    end
                end
                DONE: begin
                    state <= IDLE;    // Nothing more until the next reset
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Vertex 0 stays in place
    always_ff @(posedge clk) begin
        if (state == LOAD_REF) begin
            anchor <= pt_b;
        end
    end

    // Convex input leaves no two vertices in line with vertex 0
    a_strict_order: assert property (
        @(posedge clk) disable iff (reset) (state == COMPARE) |-> (cp != 0)
    );

endmodule

`default_nettype wire

// File: src/shoelace_area.sv
`timescale 1ns/1ps
`default_nettype none

`include "heptagon_config.svh"

module shoelace_area import heptagon_pkg::*; (
    input  wire         clk,
    input  wire         reset,
    input  wire         sort_done,
    output addr_t       area_addr,
    input  wire point_t area_pt,
    output logic        area_valid,
    output rank_t       area_rank
);

    logic        busy;
    hept_t       hept;
    logic [2:0]  step;          // 0 to 6 walk the vertices, 7 closes on vertex 0
    point_t      anchor;
    point_t      prev;
    twice_area_t acc;
    twice_area_t sum;
    twice_area_t half;
    addr_t       base;

    assign base      = addr_t'(hept) * addr_t'(`NUM_VERT);
    assign area_addr = (step == 3'(`NUM_VERT)) ? base : base + addr_t'(step);

    // Edge terms relative to vertex 0 keep every partial sum inside one heptagon
    assign sum  = acc + cross_at(anchor, prev, area_pt);
    assign half = sum >>> 1;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy       <= 1'b0;
            hept       <= '0;
            step       <= '0;
            area_valid <= 1'b0;
        end else begin
            area_valid <= 1'b0;
            if (sort_done) begin
                busy <= 1'b1;
                hept <= '0;
                step <= '0;
            end else if (busy) begin
                if (step == 3'(`NUM_VERT)) begin
                    area_valid <= 1'b1;
                    step       <= '0;
                    if (hept == hept_t'(`NUM_HEPT - 1)) begin
                        busy <= 1'b0;
                    end else begin
                        hept <= hept + 3'd1;
                    end
                end else begin
                    step <= step + 3'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (busy) begin
            prev <= area_pt;
            if (step == 3'd0) begin
                anchor <= area_pt;
                acc    <= '0;
            end else begin
                acc <= sum;
            end
            if (step == 3'(`NUM_VERT)) begin
                area_rank.index <= hept + 3'd1;
                area_rank.area  <= half[`AREA_W-1:0];
            end
        end
    end

    // Counterclockwise order from the sorter gives a positive sum
    a_area_non_negative: assert property (
        @(posedge clk) disable iff (reset)
        (busy && step == 3'(`NUM_VERT)) |-> (sum >= 0)
    );

endmodule

`default_nettype wire

// File: src/area_ranker.sv
`timescale 1ns/1ps
`default_nettype none

`include "heptagon_config.svh"

module area_ranker import heptagon_pkg::*; (
    input  wire                 clk,
    input  wire                 reset,
    input  wire                 area_valid,
    input  wire rank_t          area_rank,
    output logic                valid,
    output logic [`INDEX_W-1:0] index,
    output logic [`AREA_W-1:0]  area
);

    rank_state_t state;
    rank_t       ent [`NUM_HEPT];
    logic [2:0]  ptr;       // Collect slot, later emit slot
    logic [2:0]  head;
    logic [2:0]  scan;
    logic        ahead;

    // Larger area first, lower index wins a tie
    assign ahead = (ent[scan].area > ent[head].area) ||
                   ((ent[scan].area == ent[head].area) &&
                    (ent[scan].index < ent[head].index));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= COLLECT;
            ptr   <= '0;
            head  <= '0;
            scan  <= 3'd1;
            valid <= 1'b0;
        end else begin
            valid <= 1'b0;
            case (state)
                COLLECT: begin
                    if (area_valid) begin
                        ptr <= ptr + 3'd1;
                        if (ptr == 3'(`NUM_HEPT - 1)) begin
                            state <= SORT;
                            head  <= '0;
                            scan  <= 3'd1;
                        end
                    end
                end
                SORT: begin
                    if (scan == 3'(`NUM_HEPT - 1)) begin
                        if (head == 3'(`NUM_HEPT - 2)) begin
                            state <= EMIT;
                            ptr   <= '0;
                        end else begin
                            head <= head + 3'd1;
                            scan <= head + 3'd2;
                        end
                    end else begin
                        scan <= scan + 3'd1;
                    end
                end
                EMIT: begin
                    valid <= 1'b1;
                    ptr   <= ptr + 3'd1;
                    if (ptr == 3'(`NUM_HEPT - 1)) begin
                        state <= FINISH;
                    end
                end
                FINISH: begin
                    state <= FINISH;    // Held until reset
                end
                default: begin
                    state <= COLLECT;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == COLLECT && area_valid) begin
            ent[ptr] <= area_rank;
        end else if (state == SORT && ahead) begin
            ent[head] <= ent[scan];
            ent[scan] <= ent[head];
        end
        if (state == EMIT) begin
            index <= ent[ptr].index;
            area  <= ent[ptr].area;
        end
    end

    a_burst_length: assert property (
        @(posedge clk) disable iff (reset) valid [*5] |=> !valid
    );

endmodule

`default_nettype wire

// File: src/heptagon_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "heptagon_config.svh"

module heptagon_top import heptagon_pkg::*; (
    input  wire                  clk,
    input  wire                  reset,
    input  wire  [`COORD_W-1:0]  x,
    input  wire  [`COORD_W-1:0]  y,
    output logic                 valid,
    output logic [`INDEX_W-1:0]  index,
    output logic [`AREA_W-1:0]   area
);

    logic   load_done;
    logic   swap;
    logic   sort_done;
    logic   area_valid;
    addr_t  sort_addr_a;
    addr_t  sort_addr_b;
    addr_t  area_addr;
    point_t pt_a;
    point_t pt_b;
    point_t area_pt;
    rank_t  area_rank;

    vertex_store u_vertex_store (
        .clk         (clk),
        .reset       (reset),
        .x           (x),
        .y           (y),
        .load_done   (load_done),
        .sort_addr_a (sort_addr_a),
        .sort_addr_b (sort_addr_b),
        .swap        (swap),
        .pt_a        (pt_a),
        .pt_b        (pt_b),
        .area_addr   (area_addr),
        .area_pt     (area_pt)
    );

    angular_sorter u_angular_sorter (
        .clk         (clk),
        .reset       (reset),
        .load_done   (load_done),
        .sort_addr_a (sort_addr_a),
        .sort_addr_b (sort_addr_b),
        .pt_a        (pt_a),
        .pt_b        (pt_b),
        .swap        (swap),
        .sort_done   (sort_done)
    );

    shoelace_area u_shoelace_area (
        .clk        (clk),
        .reset      (reset),
        .sort_done  (sort_done),
        .area_addr  (area_addr),
        .area_pt    (area_pt),
        .area_valid (area_valid),
        .area_rank  (area_rank)
    );

    area_ranker u_area_ranker (
        .clk        (clk),
        .reset      (reset),
        .area_valid (area_valid),
        .area_rank  (area_rank),
        .valid      (valid),
        .index      (index),
        .area       (area)
    );

endmodule

`default_nettype wire

// File: sim/heptagon_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "heptagon_config.svh"

module heptagon_tb;

    localparam int  CLK_PERIOD = 100;
    localparam int  RUN_CYCLES = 1500;
    localparam int  NUM_RUNS   = 3;
    localparam int  MAX_WAIT   = 1000;      // Cycles from load start to first valid
    localparam real PI         = 3.14159265358979;

    logic                clk;
    logic                reset;
    logic [`COORD_W-1:0] x;
    logic [`COORD_W-1:0] y;
    logic                valid;
    logic [`INDEX_W-1:0] index;
    logic [`AREA_W-1:0]  area;

    int ccw_x [`NUM_POINTS];    // Known counterclockwise order
    int ccw_y [`NUM_POINTS];
    int drv_x [`NUM_POINTS];    // Order on the input stream
    int drv_y [`NUM_POINTS];
    int exp_idx [`NUM_HEPT];
    int exp_area [`NUM_HEPT];
    int got_idx [8];
    int got_area [8];
    int got_count;
    int errors;
    int checks;
    int failed_runs;

    heptagon_top u_heptagon_top (
        .clk   (clk),
        .reset (reset),
        .x     (x),
        .y     (y),
        .valid (valid),
        .index (index),
        .area  (area)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(negedge clk) begin
        if (reset && valid) begin
            $display("valid is high during reset at %0t", $time);
            errors++;
        end
    end

    task automatic check_value(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            $display("ERR t=%0t %s: expected %0d, got %0d", $time, name, exp, got);
            errors++;
        end
    endtask

    // Seven vertices on a circle, one per seventh of a turn, so neighbours stay apart
    task automatic make_heptagon(input int h);
        real r;
        real cx;
        real cy;
        real rot;
        real ang;
        int  v;
        r   = 150.0 + real'($urandom % 231);
        cx  = 380.0 + real'($urandom % 264);
        cy  = 380.0 + real'($urandom % 264);
        rot = real'($urandom % 360);
        for (v = 0; v < `NUM_VERT; v++) begin
            ang = (rot + v * 360.0 / `NUM_VERT + 10.0 + real'($urandom % 31)) * PI / 180.0;
            ccw_x[h * `NUM_VERT + v] = $rtoi(cx + r * $cos(ang) + 0.5);
            ccw_y[h * `NUM_VERT + v] = $rtoi(cy + r * $sin(ang) + 0.5);
        end
    endtask

    task automatic shuffle_heptagon(input int h);
        int base;
        int i;
        int j;
        int t;
        base = h * `NUM_VERT;
        for (i = 0; i < `NUM_VERT; i++) begin
            drv_x[base + i] = ccw_x[base + i];
            drv_y[base + i] = ccw_y[base + i];
        end
        for (i = `NUM_VERT - 1; i > 1; i--) begin   // Vertex 0 keeps its slot
            j = 1 + int'($urandom % i);
            t = drv_x[base + i];
            drv_x[base + i] = drv_x[base + j];
            drv_x[base + j] = t;
            t = drv_y[base + i];
            drv_y[base + i] = drv_y[base + j];
            drv_y[base + j] = t;
        end
    endtask

    function automatic int polygon_area(input int h);
        int twice;
        int i;
        int a;
        int b;
        twice = 0;
        for (i = 0; i < `NUM_VERT; i++) begin
            a = h * `NUM_VERT + i;
            b = h * `NUM_VERT + (i + 1) % `NUM_VERT;
            twice += ccw_x[a] * ccw_y[b] - ccw_x[b] * ccw_y[a];
        end
        return twice / 2;
    endfunction

    // Largest area first, lower heptagon first on a tie
    task automatic prepare_run(input bit tie);
        int areas [`NUM_HEPT];
        int order [`NUM_HEPT];
        int i;
        int j;
        int t;
        for (i = 0; i < `NUM_HEPT; i++) begin
            make_heptagon(i);
        end
        if (tie) begin
            for (i = 0; i < `NUM_VERT; i++) begin
                ccw_x[3 * `NUM_VERT + i] = ccw_x[i];
                ccw_y[3 * `NUM_VERT + i] = ccw_y[i];
            end
        end
        for (i = 0; i < `NUM_HEPT; i++) begin
            shuffle_heptagon(i);
            areas[i] = polygon_area(i);
            order[i] = i;
        end
        for (i = 0; i < `NUM_HEPT - 1; i++) begin
            for (j = i + 1; j < `NUM_HEPT; j++) begin
                if (areas[order[j]] > areas[order[i]] ||
                    (areas[order[j]] == areas[order[i]] && order[j] < order[i])) begin
                    t        = order[i];
                    order[i] = order[j];
                    order[j] = t;
                end
            end
        end
        for (i = 0; i < `NUM_HEPT; i++) begin
            exp_idx[i]  = order[i] + 1;
            exp_area[i] = areas[order[i]];
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        reset <= 1'b1;
        x     <= '0;
        y     <= '0;
        repeat (5) @(posedge clk);
    endtask

    // Point k is sampled on the (k+1)th edge after reset is released
    task automatic drive_points();
        int k;
        reset <= 1'b0;
        for (k = 0; k < `NUM_POINTS; k++) begin
            x <= drv_x[k][`COORD_W-1:0];
            y <= drv_y[k][`COORD_W-1:0];
            @(posedge clk);
        end
        x <= '0;
        y <= '0;
    endtask

    task automatic collect_burst(input int stop_after);
        int waited;
        waited    = 0;
        got_count = 0;
        @(negedge clk);
        while (!valid && waited < MAX_WAIT) begin
            @(negedge clk);
            waited++;
        end
        if (!valid) begin
            $display("No valid output within %0d cycles of the load start", MAX_WAIT);
            errors++;
        end else begin
            if (waited < `NUM_POINTS) begin
                $display("valid rose inside the load window at %0t", $time);
                errors++;
            end
            while (valid && got_count < stop_after) begin
                got_idx[got_count]  = int'(index);
                got_area[got_count] = int'(area);
                if (got_count < `NUM_HEPT) begin
                    check_value("index", got_idx[got_count], exp_idx[got_count]);
                    check_value("area", got_area[got_count], exp_area[got_count]);
                end
                got_count++;
                @(negedge clk);
            end
        end
    endtask

    task automatic check_burst(input int stop_after, input bit tie);
        int seen;
        int i;
        if (stop_after < `NUM_HEPT) begin
            if (got_count != stop_after) begin
                $display("Burst ended after %0d cycles, before the reset", got_count);
                errors++;
            end
        end else begin
            if (got_count != `NUM_HEPT) begin
                $display("Burst lasted %0d cycles instead of %0d", got_count, `NUM_HEPT);
                errors++;
            end
            repeat (20) begin
                if (valid) begin
                    $display("valid high again after the burst at %0t", $time);
                    errors++;
                end
                @(negedge clk);
            end
            seen = 0;
            for (i = 0; i < got_count && i < `NUM_HEPT; i++) begin
                seen |= 1 << got_idx[i];
            end
            if (seen != 6'b111110) begin
                $display("Output indices are not a permutation of 1 to 5");
                errors++;
            end
            for (i = 0; tie && i < got_count - 1 && i < `NUM_HEPT - 1; i++) begin
                if (got_area[i] == got_area[i + 1] && got_idx[i] > got_idx[i + 1]) begin
                    $display("Equal areas ranked with the higher index first");
                    errors++;
                end
            end
        end
    endtask

    task automatic do_run(input int run_no, input string label, input bit tie,
                          input int stop_after);
        int errors_before;
        errors_before = errors;
        prepare_run(tie);
        apply_reset();
        fork
            drive_points();
            collect_burst(stop_after);
        join
        check_burst(stop_after, tie);
        if (errors == errors_before) begin
            $display("Run %0d, %s: ok", run_no, label);
        end else begin
            $display("Run %0d, %s: %0d errors", run_no, label, errors - errors_before);
            failed_runs++;
        end
    endtask

    initial begin
        #(NUM_RUNS * RUN_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles", NUM_RUNS * RUN_CYCLES);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        x           = '0;
        y           = '0;
        errors      = 0;
        checks      = 0;
        failed_runs = 0;
        void'($urandom(32'h7567));
        do_run(1, "random heptagons", 1'b0, 8);
        do_run(2, "reset during the output burst", 1'b0, 2);
        do_run(3, "equal areas after a mid-burst reset", 1'b1, 8);
        $display("%0d runs, %0d failed, %0d value checks, %0d errors",
                 NUM_RUNS, failed_runs, checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+include
src/heptagon_pkg.sv
src/vertex_store.sv
src/angular_sorter.sv
src/shoelace_area.sv
src/area_ranker.sv
src/heptagon_top.sv
sim/heptagon_tb.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := heptagon_tb
LINT_TOP := heptagon_top
FILELIST := verilog.f
PASS_MSG := All tests passed

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(SIM) --lint-only -Wall --timing --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir
